//--- bench/rvCoreTb.sv
`timescale 1ns/100ps
`default_nettype none

module rvCoreTb import rvCorePkg::*; ();

  localparam int kOp     = 0;
  localparam int kOpImm  = 1;
  localparam int kLui    = 2;
  localparam int kAuipc  = 3;
  localparam int kBranch = 4;
  localparam int kJal    = 5;
  localparam int kJalr   = 6;
  localparam int kLoad   = 7;
  localparam int kStore  = 8;

  localparam logic [31:0] resultBase = 32'h1000;
  localparam logic [31:0] dataBase   = 32'h800;

  typedef struct packed {
    logic [3:0]  kind;
    logic [2:0]  f3;
    logic        alt;   // funct7 bit 5 for register forms
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;   // Immediate or byte offset for loads and stores
    logic [31:0] expected;
  } rowT;

  logic            clk;
  logic            reset;
  logic [xlen-1:0] dataIn;
  logic            busReady;
  logic [xlen-1:0] address;
  logic [xlen-1:0] dataOut;
  logic            busValid;
  logic            busInstr;
  logic            busWriteEnable;

  logic [31:0] mem [2048];
  rowT         rows [$];
  int          pcWord;
  int          storeCount;
  int          cycleCount;
  int          cycleLimit;
  int          waitLeft;
  int          newWait;

  rvCore i_rvCore (.*);

  bind rvCore rvCoreProperties i_rvCoreProperties (
    .clk(clk), .reset(reset), .busValid(busValid), .busReady(busReady), .busInstr(busInstr),
    .busWriteEnable(busWriteEnable), .address(address), .dataOut(dataOut)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] fillWord(input int idx);
    logic [31:0] i;
    i = 32'(idx);
    return (i * 32'h9E3779B1) ^ {i[15:0], ~i[15:0]};
  endfunction

  function automatic logic [31:0] aluModel(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] x, input logic [31:0] y);
    case (f3)
      3'd0:    return alt ? x - y : x + y;
      3'd1:    return x << y[4:0];
      3'd2:    return {31'b0, $signed(x) < $signed(y)};
      3'd3:    return {31'b0, x < y};
      3'd4:    return x ^ y;
      3'd5:    return alt ? 32'($signed(x) >>> y[4:0]) : x >> y[4:0];
      3'd6:    return x | y;
      default: return x & y;
    endcase
  endfunction

  function automatic logic branchModel(input logic [2:0] f3, input logic [31:0] x,
                                       input logic [31:0] y);
    case (f3)
      3'd1:    return x != y;
      3'd4:    return $signed(x) < $signed(y);
      3'd5:    return $signed(x) >= $signed(y);
      3'd6:    return x < y;
      3'd7:    return x >= y;
      default: return x == y;
    endcase
  endfunction

  function automatic logic [31:0] loadModel(input logic [31:0] w, input logic [1:0] off,
                                            input logic [2:0] f3);
    logic [31:0] lane;
    lane = w >> (8 * off);
    case (f3[1:0])
      2'd0:    return f3[2] ? {24'b0, lane[7:0]} : {{24{lane[7]}}, lane[7:0]};
      2'd1:    return f3[2] ? {16'b0, lane[15:0]} : {{16{lane[15]}}, lane[15:0]};
      default: return w;
    endcase
  endfunction

  function automatic logic [31:0] mergeModel(input logic [31:0] w, input logic [31:0] v,
                                             input logic [1:0] off, input logic [2:0] f3);
    logic [3:0]  mask;
    logic [31:0] shifted;
    logic [31:0] merged;
    mask    = (f3[1:0] == 2'd0) ? 4'b0001 << off : 4'b0011 << off;
    shifted = v << (8 * off);
    merged  = w;
    for (int i = 0; i < 4; i++)
      if (mask[i])
        merged[8*i +: 8] = shifted[8*i +: 8];
    return (f3[1:0] == 2'd2) ? v : merged;
  endfunction

  function automatic void addRow(input int kind, input logic [2:0] f3, input logic alt,
                                 input logic [31:0] a, input logic [31:0] b,
                                 input logic [31:0] imm);
    rowT r;
    r = '{kind: 4'(kind), f3: f3, alt: alt, a: a, b: b, imm: imm, expected: 32'b0};
    rows.push_back(r);
  endfunction

  // Instruction encoders for register numbers below 16
  function automatic logic [31:0] rType(input logic [6:0] f7, input int rs2, input int rs1,
                                        input logic [2:0] f3, input int rd);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), opOp};
  endfunction

  function automatic logic [31:0] iType(input logic [11:0] imm, input int rs1,
                                        input logic [2:0] f3, input int rd,
                                        input logic [6:0] op);
    return {imm, 5'(rs1), f3, 5'(rd), op};
  endfunction

  function automatic logic [31:0] sType(input logic [11:0] imm, input int rs2, input int rs1,
                                        input logic [2:0] f3);
    return {imm[11:5], 5'(rs2), 5'(rs1), f3, imm[4:0], opStore};
  endfunction

  function automatic logic [31:0] bType(input logic [12:0] imm, input int rs2, input int rs1,
                                        input logic [2:0] f3);
    return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11], opBranch};
  endfunction

  function automatic logic [31:0] jType(input logic [20:0] imm, input int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), opJal};
  endfunction

  task automatic emit(input logic [31:0] word);
    mem[pcWord] = word;
    pcWord++;
  endtask

  task automatic loadConst(input int rd, input logic [31:0] value);
    logic [31:0] upper;
    upper = (value + 32'h800) >> 12;
    emit({upper[19:0], 5'(rd), opLui});
    emit(iType(value[11:0], rd, 3'd0, rd, opOpImm));
  endtask

  task automatic assembleProgram();
    logic [31:0] pc;
    logic [31:0] dataAddr;
    rowT         r;
    pcWord = 0;
    emit({20'h00001, 5'd10, opLui}); // x10 points at the result area
    for (int i = 0; i < rows.size(); i++)
    begin
      r        = rows[i];
      dataAddr = dataBase + 32'(4 * i);
      case (int'(r.kind))
        kOp:
        begin
          loadConst(1, r.a);
          loadConst(2, r.b);
          emit(rType({1'b0, r.alt, 5'b0}, 2, 1, r.f3, 3));
          r.expected = aluModel(r.f3, r.alt, r.a, r.b);
        end
        kOpImm:
        begin
          loadConst(1, r.a);
          emit(iType(r.imm[11:0], 1, r.f3, 3, opOpImm));
          r.expected = aluModel(r.f3, (r.f3 == 3'd5) && r.imm[10], r.a,
                                {{20{r.imm[11]}}, r.imm[11:0]});
        end
        kLui:
        begin
          emit({r.imm[19:0], 5'd3, opLui});
          r.expected = r.imm << 12;
        end
        kAuipc:
        begin
          pc = 32'(pcWord * 4);
          emit({r.imm[19:0], 5'd3, opAuipc});
          r.expected = pc + (r.imm << 12);
        end
        kBranch:
        begin
          loadConst(1, r.a);
          loadConst(2, r.b);
          emit(iType(12'd1, 0, 3'd0, 3, opOpImm));
          emit(bType(13'd8, 2, 1, r.f3)); // Taken skips the next addi
          emit(iType(12'd2, 0, 3'd0, 3, opOpImm));
          r.expected = branchModel(r.f3, r.a, r.b) ? 32'd1 : 32'd2;
        end
        kJal:
        begin
          pc = 32'(pcWord * 4);
          emit(jType(21'd8, 3));
          emit(iType(12'h55, 0, 3'd0, 3, opOpImm)); // Must be skipped
          r.expected = pc + 4;
        end
        kJalr:
        begin
          pc = 32'((pcWord + 2) * 4);
          loadConst(1, pc + 7);
          emit(iType(12'd2, 1, 3'd0, 3, opJalr)); // Odd sum, bit 0 dropped
          emit(iType(12'h55, 0, 3'd0, 3, opOpImm));
          r.expected = pc + 4;
        end
        kLoad:
        begin
          loadConst(1, dataAddr);
          emit(iType(r.imm[11:0], 1, r.f3, 3, opLoad));
          r.expected = loadModel(fillWord(int'(dataAddr[12:2])), r.imm[1:0], r.f3);
        end
        default:
        begin
          loadConst(1, dataAddr);
          loadConst(2, r.b);
          emit(sType(r.imm[11:0], 2, 1, r.f3));
          emit(iType(12'd0, 1, 3'd2, 3, opLoad)); // Read back the whole word
          r.expected = mergeModel(fillWord(int'(dataAddr[12:2])), r.b, r.imm[1:0], r.f3);
        end
      endcase
      emit(sType(12'(4 * i), 3, 10, 3'd2));
      rows[i] = r;
    end
    emit(jType(21'd0, 0)); // Park here
  endtask

  task automatic stopWithFailure();
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic checkResult(input logic [31:0] addr, input logic [31:0] data);
    assert (storeCount < rows.size())
    else
    begin
      $display("Store to the result area after the last expected result, at %0t", $time);
      stopWithFailure();
    end
    assert (addr == resultBase + 32'(4 * storeCount))
    else
    begin
      $display("MISMATCH at %0t: address expected %h actual %h", $time,
               resultBase + 32'(4 * storeCount), addr);
      stopWithFailure();
    end
    assert (data == rows[storeCount].expected)
    else
    begin
      $display("MISMATCH at %0t: dataOut (row %0d) expected %h actual %h", $time, storeCount,
               rows[storeCount].expected, data);
      stopWithFailure();
    end
    storeCount++;
  endtask

  // Memory model with random ready delay of 0 to 3 cycles
  always @(posedge clk)
  begin
    if (reset)
    begin
      busReady <= 1'b0;
      waitLeft <= 0;
    end
    else if (busValid && busReady)
    begin
      // Program sits below the data area, so only fetches read there
      assert (busInstr == (!busWriteEnable && address < dataBase))
      else
      begin
        $display("MISMATCH at %0t: busInstr expected %b actual %b", $time,
                 !busWriteEnable && address < dataBase, busInstr);
        stopWithFailure();
      end
      if (busWriteEnable)
      begin
        mem[address[12:2]] = dataOut;
        if (address >= resultBase)
          checkResult(address, dataOut);
      end
      else
        dataIn <= mem[address[12:2]];
      newWait = int'($urandom % 4);
      waitLeft <= newWait;
      busReady <= (newWait == 0);
    end
    else if (busValid)
    begin
      if (waitLeft <= 1)
        busReady <= 1'b1;
      waitLeft <= waitLeft - 1;
    end
  end

  always @(posedge clk)
  begin
    if (!reset)
    begin
      cycleCount++;
      if (cycleCount > cycleLimit)
      begin
        $display("Timeout after %0d cycles with %0d of %0d results stored",
                 cycleCount, storeCount, rows.size());
        stopWithFailure();
      end
    end
  end

  initial
  begin
    void'($urandom(32920));
    reset      = 1'b1;
    dataIn     = '0;
    busReady   = 1'b0;
    storeCount = 0;
    cycleCount = 0;
    for (int i = 0; i < 2048; i++)
      mem[i] = fillWord(i);

    addRow(kOp, 3'd0, 1'b0, 32'd7, 32'd12, 0);
    addRow(kOp, 3'd0, 1'b1, 32'd5, 32'd9, 0);
    addRow(kOp, 3'd1, 1'b0, 32'h12345678, 32'd5, 0);
    addRow(kOp, 3'd2, 1'b0, -32'sd3, 32'd2, 0);
    addRow(kOp, 3'd2, 1'b0, 32'd5, -32'sd1, 0);
    addRow(kOp, 3'd3, 1'b0, -32'sd3, 32'd2, 0);
    addRow(kOp, 3'd4, 1'b0, 32'hF0F0_1234, 32'h0FF0_4321, 0);
    addRow(kOp, 3'd5, 1'b0, 32'h8000_00F0, 32'd4, 0);
    addRow(kOp, 3'd5, 1'b1, 32'h8000_00F0, 32'd4, 0);
    addRow(kOp, 3'd6, 1'b0, 32'h1200_0034, 32'h0056_7800, 0);
    addRow(kOp, 3'd7, 1'b0, 32'hFF00_FF00, 32'h0FF0_0FF0, 0);
    addRow(kOpImm, 3'd0, 1'b0, 32'd100, 0, 32'hFFB);
    addRow(kOpImm, 3'd2, 1'b0, -32'sd10, 0, 32'd3);
    addRow(kOpImm, 3'd3, 1'b0, 32'd5, 0, 32'hFFF);
    addRow(kOpImm, 3'd4, 1'b0, 32'h0000_5555, 0, 32'h7AA);
    addRow(kOpImm, 3'd1, 1'b0, 32'h0001_0001, 0, 32'd7);
    addRow(kOpImm, 3'd5, 1'b0, 32'hF000_0000, 0, 32'd3);
    addRow(kOpImm, 3'd5, 1'b0, 32'hF000_0000, 0, 32'h403);
    addRow(kOpImm, 3'd6, 1'b0, 32'h1000_0000, 0, 32'h0F0);
    addRow(kOpImm, 3'd7, 1'b0, 32'h1234_5678, 0, 32'h8FF);
    addRow(kLui, 3'd0, 1'b0, 0, 0, 32'hABCDE);
    addRow(kAuipc, 3'd0, 1'b0, 0, 0, 32'h12345);
    addRow(kBranch, 3'd0, 1'b0, 32'd9, 32'd9, 0);
    addRow(kBranch, 3'd0, 1'b0, 32'd9, 32'd8, 0);
    addRow(kBranch, 3'd1, 1'b0, 32'd9, 32'd8, 0);
    addRow(kBranch, 3'd4, 1'b0, -32'sd4, 32'd1, 0);
    addRow(kBranch, 3'd5, 1'b0, -32'sd4, 32'd1, 0);
    addRow(kBranch, 3'd6, 1'b0, -32'sd4, 32'd1, 0);
    addRow(kBranch, 3'd7, 1'b0, -32'sd4, 32'd1, 0);
    addRow(kJal, 3'd0, 1'b0, 0, 0, 0);
    addRow(kJalr, 3'd0, 1'b0, 0, 0, 0);
    addRow(kLoad, 3'd0, 1'b0, 0, 0, 32'd1);
    addRow(kLoad, 3'd0, 1'b0, 0, 0, 32'd3);
    addRow(kLoad, 3'd4, 1'b0, 0, 0, 32'd3);
    addRow(kLoad, 3'd1, 1'b0, 0, 0, 32'd2);
    addRow(kLoad, 3'd5, 1'b0, 0, 0, 32'd0);
    addRow(kLoad, 3'd1, 1'b0, 0, 0, 32'd0);
    addRow(kLoad, 3'd2, 1'b0, 0, 0, 32'd0);
    addRow(kLoad, 3'd0, 1'b0, 0, 0, 32'd0);
    addRow(kLoad, 3'd4, 1'b0, 0, 0, 32'd2);
    addRow(kStore, 3'd0, 1'b0, 0, 32'h0000_00A5, 32'd2);
    addRow(kStore, 3'd1, 1'b0, 0, 32'h0000_BEEF, 32'd2);
    addRow(kStore, 3'd1, 1'b0, 0, 32'h0000_1357, 32'd0);
    addRow(kStore, 3'd2, 1'b0, 0, 32'hCAFE_F00D, 32'd0);

    assembleProgram();
    // Up to about 24 cycles per instruction with the longest waits
    cycleLimit = pcWord * 24 + 100;
    if (pcWord * 4 >= int'(dataBase))
    begin
      $display("Program overlaps the data area");
      stopWithFailure();
    end

    repeat (16) @(posedge clk);
    reset <= 1'b0;
    wait (storeCount == rows.size());
    repeat (4) @(posedge clk);
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/rvCore_properties.sv
`timescale 1ns/100ps
`default_nettype none

module rvCoreProperties import rvCorePkg::*; (
  input logic            clk,
  input logic            reset,
  input logic            busValid,
  input logic            busReady,
  input logic            busInstr,
  input logic            busWriteEnable,
  input logic [xlen-1:0] address,
  input logic [xlen-1:0] dataOut
);

  // Request held steady until memory accepts it
  property holdUntilReady;
    @(posedge clk) disable iff (reset)
      busValid && !busReady |=> busValid && $stable(address) && $stable(busInstr) &&
                                $stable(busWriteEnable) && $stable(dataOut);
  endproperty

  property noWriteOnFetch;
    @(posedge clk) disable iff (reset) !(busWriteEnable && busInstr);
  endproperty

  property idleAfterReset;
    @(posedge clk) reset |=> !busValid;
  endproperty

  assert property (holdUntilReady) else $error("Bus request changed before busReady");
  assert property (noWriteOnFetch) else $error("Write enable high during an instruction fetch");
  assert property (idleAfterReset) else $error("busValid high in the cycle after reset");

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the rvCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f rvCore.f --top-module rvCoreTb -o rvCoreSim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/rvCoreSim
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation ended with status $status"
  exit $status
fi

exit 0

//--- rvCore.f
source/rvCorePkg.sv
source/immediateDecoder.sv
source/alu.sv
source/registerBank.sv
source/programCounter.sv
source/loadStoreAligner.sv
source/instructionSequencer.sv
source/rvCore.sv
bench/rvCore_properties.sv
bench/rvCoreTb.sv

//--- source/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu import rvCorePkg::*; (
  input  aluOp            operation,
  input  logic [xlen-1:0] x,
  input  logic [xlen-1:0] y,
  output logic [xlen-1:0] result
);

  localparam int shiftBits = $clog2(xlen);

  logic [shiftBits-1:0] shiftAmount;
  logic                 flag;

  assign shiftAmount = y[shiftBits-1:0];

  // Compare outcome, only used by the compare operations
  always_comb
  begin
    case (operation)
      aluLesserThanUnsigned:   flag = x < y;
      aluLesserThanSigned:     flag = $signed(x) < $signed(y);
      aluGreaterEqualUnsigned: flag = x >= y;
      aluGreaterEqualSigned:   flag = $signed(x) >= $signed(y);
      aluEqual:                flag = x == y;
      aluNotEqual:             flag = x != y;
      default:                 flag = 1'b0;
    endcase
  end

  always_comb
  begin
    case (operation)
      aluAdd:                result = x + y;
      aluSub:                result = x - y;
      aluOr:                 result = x | y;
      aluXor:                result = x ^ y;
      aluAnd:                result = x & y;
      aluShiftRightUnsigned: result = x >> shiftAmount;
      aluShiftRightSigned:   result = $signed(x) >>> shiftAmount;
      aluShiftLeft:          result = x << shiftAmount;
      aluLesserThanUnsigned, aluLesserThanSigned, aluGreaterEqualUnsigned,
      aluGreaterEqualSigned, aluEqual, aluNotEqual:
        result = {{(xlen-1){1'b0}}, flag}; // 1 or 0 in bit 0
      default:               result = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- source/immediateDecoder.sv
`timescale 1ns/100ps
`default_nettype none

module immediateDecoder import rvCorePkg::*; (
  input  logic [xlen-1:0] instruction,
  output logic [xlen-1:0] imm
);

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [11:0] immI;
  logic [11:0] immS;
  logic [12:0] immB;
  logic [20:0] immJ;

  assign opcode = instruction[6:0];
  assign funct3 = instruction[14:12];
  assign immI   = instruction[31:20];
  assign immS   = {instruction[31:25], instruction[11:7]};
  assign immB   = {instruction[31], instruction[7], instruction[30:25], instruction[11:8], 1'b0};
  assign immJ   = {instruction[31], instruction[19:12], instruction[20], instruction[30:21], 1'b0};

  always_comb
  begin
    case (opcode)
      opOpImm:
      begin
        if (funct3 == 3'b001 || funct3 == 3'b101)
          imm = {{(xlen-12){1'b0}}, immI}; // Shift amount plus funct7 bits
        else
          imm = {{(xlen-12){immI[11]}}, immI};
      end
      opLoad, opJalr: imm = {{(xlen-12){immI[11]}}, immI};
      opStore:        imm = {{(xlen-12){immS[11]}}, immS};
      opBranch:       imm = {{(xlen-13){immB[12]}}, immB};
      opLui, opAuipc: imm = {instruction[31:12], 12'b0};
      opJal:          imm = {{(xlen-21){immJ[20]}}, immJ};
      default:        imm = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- source/instructionSequencer.sv
`timescale 1ns/100ps
`default_nettype none

module instructionSequencer import rvCorePkg::*; (
  input  logic            clk,
  input  logic            reset,
  input  logic [xlen-1:0] dataIn,
  input  logic            busReady,
  input  logic [xlen-1:0] imm,
  input  logic [xlen-1:0] regOutA,
  input  logic [xlen-1:0] regOutB,
  input  logic [xlen-1:0] aluResult,
  input  logic [xlen-1:0] pcNext,
  input  logic [xlen-1:0] pcCurrent,
  input  logic [xlen-1:0] loadData,
  input  logic [xlen-1:0] mergedStoreData,
  output logic [xlen-1:0] address,
  output logic [xlen-1:0] dataOut,
  output logic            busValid,
  output logic            busInstr,
  output logic            busWriteEnable,
  output logic [xlen-1:0] instruction,
  output regIndex         regNumA,
  output regIndex         regNumB,
  output regIndex         writeRegNum,
  output logic [xlen-1:0] writeRegData,
  output logic            writeRegEnable,
  output logic            pcJump,
  output logic            pcJumpRelative,
  output logic [xlen-1:0] pcTarget,
  output logic            pcStep,
  output aluOp            aluOperation,
  output logic [xlen-1:0] aluX,
  output logic [xlen-1:0] aluY,
  output logic [1:0]      byteOffset,
  output logic [1:0]      transferSize,
  output logic            loadUnsigned
);

  seqState         state;
  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic            altFunct; // funct7 bit 5
  logic [xlen-1:0] jumpTarget;
  logic            branchTaken;

  assign opcode       = instruction[6:0];
  assign funct3       = instruction[14:12];
  assign altFunct     = instruction[30];
  assign regNumA      = instruction[18:15];
  assign regNumB      = instruction[23:20];
  assign writeRegNum  = instruction[10:7];
  assign transferSize = funct3[1:0];
  assign loadUnsigned = funct3[2];

  assign jumpTarget  = {aluResult[xlen-1:1], 1'b0};
  assign branchTaken = (opcode == opBranch) && aluResult[0];

  // PC steps on the edge that completes the fetch
  assign pcStep         = (state == fetch) && busValid && busReady;
  assign pcJump         = (state == execute1) &&
                          (opcode == opJal || opcode == opJalr || branchTaken);
  assign pcJumpRelative = (opcode == opBranch);
  assign pcTarget       = pcJumpRelative ? imm : jumpTarget;

  always_ff @(posedge clk)
  begin
    logic fetchNext;
    fetchNext = 1'b0;
    if (reset)
    begin
      state          <= fetch;
      busValid       <= 1'b0;
      busInstr       <= 1'b0;
      busWriteEnable <= 1'b0;
      writeRegEnable <= 1'b0;
    end
    else
    begin
      writeRegEnable <= 1'b0; // Single cycle write pulse
      case (state)
        fetch:
        begin
          if (!busValid)
            fetchNext = 1'b1; // First fetch after reset
          else if (busReady)
          begin
            busValid <= 1'b0;
            busInstr <= 1'b0;
            state    <= decode;
          end
        end
        decode:
        begin
          instruction <= dataIn;
          state       <= execute0;
        end
        execute0:
        begin
          state <= execute1;
          case (opcode)
            opOp, opOpImm:
            begin
              aluX <= regOutA;
              aluY <= (opcode == opOp) ? regOutB : imm;
              case (funct3)
                3'd0:    aluOperation <= (opcode == opOp && altFunct) ? aluSub : aluAdd;
                3'd1:    aluOperation <= aluShiftLeft;
                3'd2:    aluOperation <= aluLesserThanSigned;
                3'd3:    aluOperation <= aluLesserThanUnsigned;
                3'd4:    aluOperation <= aluXor;
                3'd5:    aluOperation <= altFunct ? aluShiftRightSigned : aluShiftRightUnsigned;
                3'd6:    aluOperation <= aluOr;
                default: aluOperation <= aluAnd;
              endcase
            end
            opBranch:
            begin
              aluX <= regOutA;
              aluY <= regOutB;
              case (funct3)
                3'd1:    aluOperation <= aluNotEqual;
                3'd4:    aluOperation <= aluLesserThanSigned;
                3'd5:    aluOperation <= aluGreaterEqualSigned;
                3'd6:    aluOperation <= aluLesserThanUnsigned;
                3'd7:    aluOperation <= aluGreaterEqualUnsigned;
                default: aluOperation <= aluEqual;
              endcase
            end
            opAuipc, opJal:
            begin
              aluX         <= pcCurrent; // Instruction address
              aluY         <= imm;
              aluOperation <= aluAdd;
            end
            opJalr, opLoad, opStore:
            begin
              aluX         <= regOutA;
              aluY         <= imm;
              aluOperation <= aluAdd;
            end
            opLui:
            begin
              writeRegData   <= imm;
              writeRegEnable <= 1'b1;
              fetchNext = 1'b1;
            end
            default: fetchNext = 1'b1; // Unknown opcode is skipped
          endcase
        end
        execute1:
        begin
          case (opcode)
            opOp, opOpImm, opAuipc:
            begin
              writeRegData   <= aluResult;
              writeRegEnable <= 1'b1;
              fetchNext = 1'b1;
            end
            opJal, opJalr:
            begin
              writeRegData   <= pcNext; // Instruction address plus 4
              writeRegEnable <= 1'b1;
              address        <= jumpTarget;
              busValid       <= 1'b1;
              busInstr       <= 1'b1;
              state          <= fetch;
            end
            opBranch:
            begin
              if (aluResult[0])
                state <= execute2;
              else
                fetchNext = 1'b1;
            end
            opLoad, opStore:
            begin
              if (!busValid)
              begin
                address    <= {aluResult[xlen-1:2], 2'b00};
                byteOffset <= aluResult[1:0];
                busValid   <= 1'b1;
              end
              else if (busReady)
              begin
                busValid <= 1'b0;
                state    <= execute2;
              end
            end
            default: fetchNext = 1'b1;
          endcase
        end
        execute2:
        begin
          case (opcode)
            opLoad:
            begin
              writeRegData   <= loadData;
              writeRegEnable <= 1'b1;
              fetchNext = 1'b1;
            end
            opStore:
            begin
              // Old word is on dataIn only in the first cycle here
              if (!busValid)
              begin
                dataOut        <= mergedStoreData;
                busWriteEnable <= 1'b1;
                busValid       <= 1'b1;
              end
              else if (busReady)
              begin
                busValid       <= 1'b0;
                busWriteEnable <= 1'b0;
                state          <= execute3;
              end
            end
            default: state <= execute3; // Taken branch, PC settles
          endcase
        end
        execute3: fetchNext = 1'b1;
        default:  fetchNext = 1'b1;
      endcase
      if (fetchNext)
      begin
        address  <= pcNext;
        busValid <= 1'b1;
        busInstr <= 1'b1;
        state    <= fetch;
      end
    end
  end

endmodule

`default_nettype wire

//--- source/loadStoreAligner.sv
`timescale 1ns/100ps
`default_nettype none

module loadStoreAligner import rvCorePkg::*; (
  input  logic [xlen-1:0] word,
  input  logic [xlen-1:0] storeValue,
  input  logic [1:0]      byteOffset,
  input  logic [1:0]      transferSize,
  input  logic            loadUnsigned,
  output logic [xlen-1:0] loadData,
  output logic [xlen-1:0] mergedStoreData
);

  localparam int laneCount = xlen / 8;

  logic [xlen-1:0]      laneShift;
  logic [xlen-1:0]      loadLane;
  logic [xlen-1:0]      storeLane;
  logic [laneCount-1:0] byteMask;

  assign laneShift = {{(xlen-5){1'b0}}, byteOffset, 3'b000};
  assign loadLane  = word >> laneShift;

  // Size 0 is a byte, 1 a half word, 2 a full word
  always_comb
  begin
    case (transferSize)
      2'd0:
        loadData = loadUnsigned ? {{(xlen-8){1'b0}}, loadLane[7:0]}
                                : {{(xlen-8){loadLane[7]}}, loadLane[7:0]};
      2'd1:
        loadData = loadUnsigned ? {{(xlen-16){1'b0}}, loadLane[15:0]}
                                : {{(xlen-16){loadLane[15]}}, loadLane[15:0]};
      default:
        loadData = word;
    endcase
  end

  always_comb
  begin
    case (transferSize)
      2'd0:    byteMask = laneCount'(4'b0001) << byteOffset;
      2'd1:    byteMask = laneCount'(4'b0011) << byteOffset;
      default: byteMask = '1;
    endcase
  end

  // Word stores ignore the offset
  assign storeLane = (transferSize == 2'd2) ? storeValue : storeValue << laneShift;

  always_comb
  begin
    for (int i = 0; i < laneCount; i++)
      mergedStoreData[8*i +: 8] = byteMask[i] ? storeLane[8*i +: 8] : word[8*i +: 8];
  end

endmodule

`default_nettype wire

//--- source/programCounter.sv
`timescale 1ns/100ps
`default_nettype none

module programCounter import rvCorePkg::*; #(
  parameter logic [xlen-1:0] resetAddress = '0
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            step,
  input  logic            jump,
  input  logic            jumpRelative,
  input  logic [xlen-1:0] target,
  output logic [xlen-1:0] next,
  output logic [xlen-1:0] current
);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      next    <= resetAddress;
      current <= resetAddress;
    end
    else if (step)
    begin
      current <= next; // Address of the word just fetched
      next    <= next + 4;
    end
    else if (jump)
      next <= jumpRelative ? current + target : target;
  end

endmodule

`default_nettype wire

//--- source/registerBank.sv
`timescale 1ns/100ps
`default_nettype none

module registerBank import rvCorePkg::*; #(
  parameter int registerCount = 16
) (
  input  logic            clk,
  input  logic            reset,
  input  regIndex         numA,
  input  regIndex         numB,
  input  regIndex         writeNum,
  input  logic [xlen-1:0] writeData,
  input  logic            writeEnable,
  output logic [xlen-1:0] outA,
  output logic [xlen-1:0] outB
);

  logic [xlen-1:0] regs [registerCount];

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < registerCount; i++)
        regs[i] <= '0;
    end
    else if (writeEnable && writeNum != '0) // x0 stays zero
      regs[writeNum] <= writeData;
  end

  assign outA = (numA == '0) ? '0 : regs[numA];
  assign outB = (numB == '0) ? '0 : regs[numB];

endmodule

`default_nettype wire

//--- source/rvCore.sv
`timescale 1ns/100ps
`default_nettype none

module rvCore import rvCorePkg::*; #(
  parameter logic [xlen-1:0] resetAddress  = '0,
  parameter int              registerCount = 16
) (
  input  logic            clk,
  input  logic            reset,
  input  logic [xlen-1:0] dataIn,
  input  logic            busReady,
  output logic [xlen-1:0] address,
  output logic [xlen-1:0] dataOut,
  output logic            busValid,
  output logic            busInstr,
  output logic            busWriteEnable
);

  logic [xlen-1:0] instruction;
  logic [xlen-1:0] imm;
  logic [xlen-1:0] regOutA;
  logic [xlen-1:0] regOutB;
  regIndex         regNumA;
  regIndex         regNumB;
  regIndex         writeRegNum;
  logic [xlen-1:0] writeRegData;
  logic            writeRegEnable;
  logic [xlen-1:0] pcNext;
  logic [xlen-1:0] pcCurrent;
  logic [xlen-1:0] pcTarget;
  logic            pcStep;
  logic            pcJump;
  logic            pcJumpRelative;
  aluOp            aluOperation;
  logic [xlen-1:0] aluX;
  logic [xlen-1:0] aluY;
  logic [xlen-1:0] aluResult;
  logic [1:0]      byteOffset;
  logic [1:0]      transferSize;
  logic            loadUnsigned;
  logic [xlen-1:0] loadData;
  logic [xlen-1:0] mergedStoreData;

  instructionSequencer i_instructionSequencer (
    .clk, .reset, .dataIn, .busReady, .imm, .regOutA, .regOutB, .aluResult,
    .pcNext, .pcCurrent, .loadData, .mergedStoreData, .address, .dataOut,
    .busValid, .busInstr, .busWriteEnable, .instruction, .regNumA, .regNumB,
    .writeRegNum, .writeRegData, .writeRegEnable, .pcJump, .pcJumpRelative,
    .pcTarget, .pcStep, .aluOperation, .aluX, .aluY, .byteOffset, .transferSize,
    .loadUnsigned
  );

  immediateDecoder i_immediateDecoder (.instruction, .imm);

  alu i_alu (.operation(aluOperation), .x(aluX), .y(aluY), .result(aluResult));

  registerBank #(.registerCount(registerCount)) i_registerBank (
    .clk, .reset, .numA(regNumA), .numB(regNumB), .writeNum(writeRegNum),
    .writeData(writeRegData), .writeEnable(writeRegEnable), .outA(regOutA), .outB(regOutB)
  );

  programCounter #(.resetAddress(resetAddress)) i_programCounter (
    .clk, .reset, .step(pcStep), .jump(pcJump), .jumpRelative(pcJumpRelative),
    .target(pcTarget), .next(pcNext), .current(pcCurrent)
  );

  // Old memory word comes straight from the bus
  loadStoreAligner i_loadStoreAligner (
    .word(dataIn), .storeValue(regOutB), .byteOffset, .transferSize, .loadUnsigned,
    .loadData, .mergedStoreData
  );

endmodule

`default_nettype wire

//--- source/rvCorePkg.sv
`default_nettype none

package rvCorePkg;

  // Data and address width
  localparam int xlen = 32;

  // RV32I major opcodes
  localparam logic [6:0] opLoad   = 7'b0000011;
  localparam logic [6:0] opStore  = 7'b0100011;
  localparam logic [6:0] opBranch = 7'b1100011;
  localparam logic [6:0] opJal    = 7'b1101111;
  localparam logic [6:0] opJalr   = 7'b1100111;
  localparam logic [6:0] opOpImm  = 7'b0010011;
  localparam logic [6:0] opOp     = 7'b0110011;
  localparam logic [6:0] opLui    = 7'b0110111;
  localparam logic [6:0] opAuipc  = 7'b0010111;

  typedef enum logic [3:0] {
    aluAdd,
    aluSub,
    aluOr,
    aluXor,
    aluAnd,
    aluLesserThanUnsigned,
    aluLesserThanSigned,
    aluShiftRightUnsigned,
    aluShiftRightSigned,
    aluShiftLeft,
    aluGreaterEqualUnsigned,
    aluGreaterEqualSigned,
    aluEqual,
    aluNotEqual
  } aluOp;

  // Sequencer states
  typedef enum logic [2:0] {
    fetch,
    decode,
    execute0,
    execute1,
    execute2,
    execute3
  } seqState;

  // Register number, widen for a 32 entry bank
  typedef logic [3:0] regIndex;

endpackage

`default_nettype wire
